// File: design/phy_rx_pkg.sv
// 10G PCS receive link monitor shared codes, enums and counter limits
`default_nettype none

package phy_rx_pkg;

    // 64b/66b sync header
    localparam int hdr_w = 2;
    localparam logic [hdr_w-1:0] sync_data = 2'b10;
    localparam logic [hdr_w-1:0] sync_ctrl = 2'b01;

    // 125 us at 6.4 ns per block
    localparam int default_window_cycles = 19531;

    // block lock limits, counted over groups of 64 headers
    localparam int lock_good_count = 64;
    localparam int lock_bad_limit = 16;
    localparam int slip_hold_cycles = 4;

    // invalid headers per window for high BER
    localparam int ber_bad_limit = 16;

    // saturating block error count per watchdog window
    localparam int block_err_limit = 1023;

    // control block type field, data bits 7:0
    typedef enum logic [7:0] {
        bt_ctrl    = 8'h1e,
        bt_start_4 = 8'h33,
        bt_os      = 8'h4b,
        bt_start_0 = 8'h78,
        bt_term_0  = 8'h87,
        bt_term_1  = 8'h99,
        bt_term_2  = 8'haa,
        bt_term_3  = 8'hb4,
        bt_term_4  = 8'hcc,
        bt_term_5  = 8'hd2,
        bt_term_6  = 8'he1,
        bt_term_7  = 8'hff
    } block_type_t;

    typedef enum logic [1:0] {
        lock_reset,
        lock_test,
        lock_slip,
        lock_good
    } lock_state_t;

endpackage

`default_nettype wire

// File: design/rx_block_lock.sv
// block lock FSM, aligns on valid sync headers and requests gearbox bit-slips
`timescale 1ns/1ps
`default_nettype none

module rx_block_lock (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [phy_rx_pkg::hdr_w-1:0] serdes_rx_hdr,
    output logic                              serdes_rx_bitslip,
    output logic                              rx_block_lock
);
    import phy_rx_pkg::*;

    localparam int sh_cnt_w = $clog2(lock_good_count);
    localparam int bad_cnt_w = $clog2(lock_bad_limit);
    localparam int hold_w = $clog2(slip_hold_cycles);

    lock_state_t          state;
    logic [sh_cnt_w-1:0]  sh_cnt;
    logic [bad_cnt_w-1:0] bad_cnt;
    logic [hold_w-1:0]    hold_cnt;
    logic                 sh_valid;
    logic                 group_end;

    assign sh_valid = (serdes_rx_hdr == sync_data) || (serdes_rx_hdr == sync_ctrl);
    assign group_end = (sh_cnt == sh_cnt_w'(lock_good_count - 1));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= lock_reset;
            sh_cnt <= '0;
            bad_cnt <= '0;
            hold_cnt <= '0;
            serdes_rx_bitslip <= 1'b0;
            rx_block_lock <= 1'b0;
        end else begin
            serdes_rx_bitslip <= 1'b0;
            case (state)
                lock_reset: begin
                    sh_cnt <= '0;
                    bad_cnt <= '0;
                    rx_block_lock <= 1'b0;
                    state <= lock_test;
                end
                lock_test: begin
                    // searching, any invalid header means wrong alignment
                    if (!sh_valid) begin
                        serdes_rx_bitslip <= 1'b1;
                        hold_cnt <= hold_w'(slip_hold_cycles - 1);
                        sh_cnt <= '0;
                        bad_cnt <= '0;
                        state <= lock_slip;
                    end else if (group_end) begin
                        sh_cnt <= '0;
                        rx_block_lock <= 1'b1;
                        state <= lock_good;
                    end else begin
                        sh_cnt <= sh_cnt + 1'b1;
                    end
                end
                lock_good: begin
                    if (!sh_valid && bad_cnt == bad_cnt_w'(lock_bad_limit - 1)) begin
                        serdes_rx_bitslip <= 1'b1;
                        rx_block_lock <= 1'b0;
                        hold_cnt <= hold_w'(slip_hold_cycles - 1);
                        sh_cnt <= '0;
                        bad_cnt <= '0;
                        state <= lock_slip;
                    end else if (group_end) begin
                        // group done with fewer than the limit, lock holds
                        sh_cnt <= '0;
                        bad_cnt <= '0;
                    end else begin
                        sh_cnt <= sh_cnt + 1'b1;
                        if (!sh_valid) begin
                            bad_cnt <= bad_cnt + 1'b1;
                        end
                    end
                end
                lock_slip: begin
                    // headers masked while the gearbox settles
                    if (hold_cnt == '0) begin
                        state <= lock_test;
                    end else begin
                        hold_cnt <= hold_cnt - 1'b1;
                    end
                end
                default: begin
                    state <= lock_reset;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: design/rx_ber_monitor.sv
// bit error rate monitor, counts invalid sync headers per window
`timescale 1ns/1ps
`default_nettype none

module rx_ber_monitor #(
    parameter int window_cycles = phy_rx_pkg::default_window_cycles
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [phy_rx_pkg::hdr_w-1:0] serdes_rx_hdr,
    input  wire logic                         rx_block_lock,
    output logic                              rx_high_ber
);
    import phy_rx_pkg::*;

    localparam int win_w = $clog2(window_cycles + 1);
    localparam int ber_cnt_w = $clog2(ber_bad_limit + 1);

    logic [win_w-1:0]     win_cnt;
    logic [ber_cnt_w-1:0] ber_cnt;
    logic [ber_cnt_w-1:0] ber_cnt_next;
    logic                 hdr_bad;

    assign hdr_bad = rx_block_lock && (serdes_rx_hdr != sync_data)
                     && (serdes_rx_hdr != sync_ctrl);

    // saturates at the limit, includes the header of the current cycle
    always_comb begin
        ber_cnt_next = ber_cnt;
        if (hdr_bad && ber_cnt != ber_cnt_w'(ber_bad_limit)) begin
            ber_cnt_next = ber_cnt + 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            win_cnt <= win_w'(window_cycles);
            ber_cnt <= '0;
            rx_high_ber <= 1'b0;
        end else begin
            if (win_cnt == '0) begin
                win_cnt <= win_w'(window_cycles);
                ber_cnt <= '0;
                rx_high_ber <= (ber_cnt_next == ber_cnt_w'(ber_bad_limit));
            end else begin
                win_cnt <= win_cnt - 1'b1;
                ber_cnt <= ber_cnt_next;
            end
        end
    end

endmodule

`default_nettype wire

// File: design/rx_block_checker.sv
// control block checker, flags unknown block types and start/terminate order errors
`timescale 1ns/1ps
`default_nettype none

module rx_block_checker (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [phy_rx_pkg::hdr_w-1:0] serdes_rx_hdr,
    input  wire logic [63:0]                  serdes_rx_data,
    input  wire logic                         rx_block_lock,
    output logic                              rx_bad_block,
    output logic                              rx_sequence_error
);
    import phy_rx_pkg::*;

    block_type_t blk_type;
    logic        hdr_valid;
    logic        is_ctrl;
    logic        type_legal;
    logic        is_start;
    logic        is_term;
    logic        in_frame;

    assign blk_type = block_type_t'(serdes_rx_data[7:0]);
    assign hdr_valid = (serdes_rx_hdr == sync_data) || (serdes_rx_hdr == sync_ctrl);
    assign is_ctrl = (serdes_rx_hdr == sync_ctrl);

    always_comb begin
        type_legal = 1'b0;
        is_start = 1'b0;
        is_term = 1'b0;
        case (blk_type)
            bt_ctrl, bt_os: begin
                type_legal = 1'b1;
            end
            bt_start_0, bt_start_4: begin
                type_legal = 1'b1;
                is_start = 1'b1;
            end
            bt_term_0, bt_term_1, bt_term_2, bt_term_3,
            bt_term_4, bt_term_5, bt_term_6, bt_term_7: begin
                type_legal = 1'b1;
                is_term = 1'b1;
            end
            default: begin
                type_legal = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rx_bad_block <= 1'b0;
            rx_sequence_error <= 1'b0;
            in_frame <= 1'b0;
        end else begin
            rx_bad_block <= 1'b0;
            rx_sequence_error <= 1'b0;
            if (!rx_block_lock) begin
                // frame state means nothing without alignment
                in_frame <= 1'b0;
            end else if (!hdr_valid) begin
                rx_bad_block <= 1'b1;
            end else if (is_ctrl) begin
                if (!type_legal) begin
                    rx_bad_block <= 1'b1;
                end else if (is_start) begin
                    rx_sequence_error <= in_frame;
                    in_frame <= 1'b1;
                end else if (is_term) begin
                    rx_sequence_error <= !in_frame;
                    in_frame <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: design/rx_watchdog.sv
// serdes watchdog, window based link status and serdes reset request
`timescale 1ns/1ps
`default_nettype none

module rx_watchdog #(
    parameter int window_cycles = phy_rx_pkg::default_window_cycles
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [phy_rx_pkg::hdr_w-1:0] serdes_rx_hdr,
    input  wire logic                         rx_bad_block,
    input  wire logic                         rx_sequence_error,
    input  wire logic                         rx_block_lock,
    input  wire logic                         rx_high_ber,
    output logic                              serdes_rx_reset_req,
    output logic                              rx_status
);
    import phy_rx_pkg::*;

    localparam int win_w = $clog2(window_cycles + 1);
    localparam int blk_err_w = $clog2(block_err_limit + 1);

    logic [win_w-1:0]     time_cnt;
    logic [win_w-1:0]     time_cnt_next;
    logic [3:0]           error_cnt;
    logic [3:0]           error_cnt_next;
    logic [3:0]           status_cnt;
    logic [3:0]           status_cnt_next;
    logic                 saw_ctrl;
    logic                 saw_ctrl_next;
    logic                 saw_high_ber;
    logic                 saw_high_ber_next;
    logic [blk_err_w-1:0] blk_err_cnt;
    logic [blk_err_w-1:0] blk_err_cnt_next;
    logic                 reset_req_next;
    logic                 status_next;
    logic                 win_bad;

    // no control header, high BER, or too many block errors
    assign win_bad = !saw_ctrl || saw_high_ber
                     || (blk_err_cnt == blk_err_w'(block_err_limit));

    always_comb begin
        time_cnt_next = time_cnt;
        error_cnt_next = error_cnt;
        status_cnt_next = status_cnt;
        saw_ctrl_next = saw_ctrl;
        saw_high_ber_next = saw_high_ber || rx_high_ber;
        blk_err_cnt_next = blk_err_cnt;
        reset_req_next = 1'b0;
        status_next = rx_status;

        if (rx_block_lock) begin
            if (serdes_rx_hdr == sync_ctrl) begin
                saw_ctrl_next = 1'b1;
            end
            if ((rx_bad_block || rx_sequence_error)
                    && blk_err_cnt != blk_err_w'(block_err_limit)) begin
                blk_err_cnt_next = blk_err_cnt + 1'b1;
            end
        end

        if (time_cnt != '0) begin
            time_cnt_next = time_cnt - 1'b1;
        end else begin
            time_cnt_next = win_w'(window_cycles);
            if (win_bad) begin
                status_cnt_next = '0;
                status_next = 1'b0;
                if (&error_cnt) begin
                    error_cnt_next = '0;
                    reset_req_next = 1'b1;
                end else begin
                    error_cnt_next = error_cnt + 1'b1;
                end
            end else begin
                error_cnt_next = '0;
                if (&status_cnt) begin
                    status_next = 1'b1;
                end else begin
                    status_cnt_next = status_cnt + 1'b1;
                end
            end
            saw_ctrl_next = 1'b0;
            saw_high_ber_next = 1'b0;
            blk_err_cnt_next = '0;
        end

        // lock loss wins over a good window end
        if (!rx_block_lock) begin
            status_next = 1'b0;
            status_cnt_next = '0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            time_cnt <= win_w'(window_cycles);
            error_cnt <= '0;
            status_cnt <= '0;
            saw_ctrl <= 1'b0;
            saw_high_ber <= 1'b0;
            blk_err_cnt <= '0;
            serdes_rx_reset_req <= 1'b0;
            rx_status <= 1'b0;
        end else begin
            time_cnt <= time_cnt_next;
            error_cnt <= error_cnt_next;
            status_cnt <= status_cnt_next;
            saw_ctrl <= saw_ctrl_next;
            saw_high_ber <= saw_high_ber_next;
            blk_err_cnt <= blk_err_cnt_next;
            serdes_rx_reset_req <= reset_req_next;
            rx_status <= status_next;
        end
    end

endmodule

`default_nettype wire

// File: design/phy_rx_monitor_top.sv
// 10G PCS receive link monitor, block lock, BER, block checks and watchdog
`timescale 1ns/1ps
`default_nettype none

module phy_rx_monitor_top #(
    parameter int window_cycles = phy_rx_pkg::default_window_cycles
) (
    input  wire logic                         clk,
    input  wire logic                         rst,
    input  wire logic [phy_rx_pkg::hdr_w-1:0] serdes_rx_hdr,
    input  wire logic [63:0]                  serdes_rx_data,
    output wire logic                         serdes_rx_bitslip,
    output wire logic                         serdes_rx_reset_req,
    output wire logic                         rx_block_lock,
    output wire logic                         rx_high_ber,
    output wire logic                         rx_bad_block,
    output wire logic                         rx_sequence_error,
    output wire logic                         rx_status
);

    rx_block_lock i_rx_block_lock (
        .clk               (clk),
        .rst               (rst),
        .serdes_rx_hdr     (serdes_rx_hdr),
        .serdes_rx_bitslip (serdes_rx_bitslip),
        .rx_block_lock     (rx_block_lock)
    );

    rx_ber_monitor #(
        .window_cycles (window_cycles)
    ) i_rx_ber_monitor (
        .clk           (clk),
        .rst           (rst),
        .serdes_rx_hdr (serdes_rx_hdr),
        .rx_block_lock (rx_block_lock),
        .rx_high_ber   (rx_high_ber)
    );

    rx_block_checker i_rx_block_checker (
        .clk               (clk),
        .rst               (rst),
        .serdes_rx_hdr     (serdes_rx_hdr),
        .serdes_rx_data    (serdes_rx_data),
        .rx_block_lock     (rx_block_lock),
        .rx_bad_block      (rx_bad_block),
        .rx_sequence_error (rx_sequence_error)
    );

    // high BER feeds the watchdog as a bad window marker
    rx_watchdog #(
        .window_cycles (window_cycles)
    ) i_rx_watchdog (
        .clk                 (clk),
        .rst                 (rst),
        .serdes_rx_hdr       (serdes_rx_hdr),
        .rx_bad_block        (rx_bad_block),
        .rx_sequence_error   (rx_sequence_error),
        .rx_block_lock       (rx_block_lock),
        .rx_high_ber         (rx_high_ber),
        .serdes_rx_reset_req (serdes_rx_reset_req),
        .rx_status           (rx_status)
    );

endmodule

`default_nettype wire

// File: tests/phy_rx_monitor_tb.sv
// testbench for the receive link monitor, runs test phases from a data file
`timescale 1ns/1ps
`default_nettype none

module phy_rx_monitor_tb;
    import phy_rx_pkg::*;

    localparam int max_tests = 16;
    localparam int fields = 10;

    logic        clk;
    logic        rst;
    logic [1:0]  serdes_rx_hdr;
    logic [63:0] serdes_rx_data;
    logic        serdes_rx_bitslip;
    logic        serdes_rx_reset_req;
    logic        rx_block_lock;
    logic        rx_high_ber;
    logic        rx_bad_block;
    logic        rx_sequence_error;
    logic        rx_status;

    logic [15:0] test_mem [0:max_tests*fields-1];
    logic [15:0] lfsr_state;
    block_type_t last_type;
    logic        last_type_bad;
    logic        ctrl_pending;
    logic        ctrl_driven;
    int          num_tests;
    int          cycles;
    int          cycle_limit;
    int          check_total;
    int          error_total;
    int          slip_cnt;
    int          reset_cnt;
    int          bad_cnt;
    int          seq_cnt;

    phy_rx_monitor_top #(
        .window_cycles (63)
    ) i_phy_rx_monitor_top (
        .clk                 (clk),
        .rst                 (rst),
        .serdes_rx_hdr       (serdes_rx_hdr),
        .serdes_rx_data      (serdes_rx_data),
        .serdes_rx_bitslip   (serdes_rx_bitslip),
        .serdes_rx_reset_req (serdes_rx_reset_req),
        .rx_block_lock       (rx_block_lock),
        .rx_high_ber         (rx_high_ber),
        .rx_bad_block        (rx_bad_block),
        .rx_sequence_error   (rx_sequence_error),
        .rx_status           (rx_status)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout, run did not finish within %0d cycles", cycle_limit);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    task automatic take_bits(input int n, output logic [63:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr_state = lfsr_next(lfsr_state);
            v = {v[62:0], lfsr_state[0]};
        end
    endtask

    function automatic logic is_legal_type(input block_type_t t);
        case (t)
            bt_ctrl, bt_start_4, bt_os, bt_start_0, bt_term_0, bt_term_1,
            bt_term_2, bt_term_3, bt_term_4, bt_term_5, bt_term_6, bt_term_7: begin
                return 1'b1;
            end
            default: begin
                return 1'b0;
            end
        endcase
    endfunction

    task automatic check_flag(input int test, input string name, input logic got,
                              input logic exp);
        check_total++;
        if (got !== exp) begin
            error_total++;
            $display("FAILED test %02h %s: got 0x%0h expected 0x%0h", test, name, got, exp);
        end
    endtask

    task automatic check_count(input int test, input string name, input int got,
                               input int exp);
        check_total++;
        if (got != exp) begin
            error_total++;
            $display("FAILED test %02h %s pulses: got 0x%0h expected 0x%0h",
                     test, name, got, exp);
        end
    endtask

    // an unknown type byte in a locked control block must be flagged bad
    task automatic check_block_type(input int test, input block_type_t blk_type,
                                    input logic flagged);
        logic exp_bad;
        exp_bad = !is_legal_type(blk_type);
        check_total++;
        if (flagged !== exp_bad) begin
            error_total++;
            $display("FAILED test %02h rx_bad_block type 0x%02h: got 0x%0h expected 0x%0h",
                     test, blk_type, flagged, exp_bad);
        end
    endtask

    // pulses seen at a falling edge belong to the block driven before it
    task automatic sample_outputs();
        if (serdes_rx_bitslip) slip_cnt++;
        if (serdes_rx_reset_req) reset_cnt++;
        if (rx_bad_block) bad_cnt++;
        if (rx_sequence_error) seq_cnt++;
        if (ctrl_pending) begin
            last_type_bad = rx_bad_block;
            ctrl_driven = 1'b1;
            ctrl_pending = 1'b0;
        end
    endtask

    task automatic finish_test(input int t);
        int base;
        int code;
        int errors_before;
        base = t * fields;
        code = int'(test_mem[base]);
        errors_before = error_total;
        check_flag(code, "rx_block_lock", rx_block_lock, test_mem[base+3][0]);
        check_flag(code, "rx_high_ber", rx_high_ber, test_mem[base+4][0]);
        check_flag(code, "rx_status", rx_status, test_mem[base+5][0]);
        check_count(code, "serdes_rx_bitslip", slip_cnt, int'(test_mem[base+6]));
        check_count(code, "serdes_rx_reset_req", reset_cnt, int'(test_mem[base+7]));
        check_count(code, "rx_bad_block", bad_cnt, int'(test_mem[base+8]));
        check_count(code, "rx_sequence_error", seq_cnt, int'(test_mem[base+9]));
        if (ctrl_driven) begin
            check_block_type(code, last_type, last_type_bad);
        end
        $display("test %02h mode %0d blocks %0d: %s", test_mem[base], test_mem[base+1],
                 test_mem[base+2], (error_total == errors_before) ? "ok" : "failed");
    endtask

    task automatic drive_block(input int mode, input int i, input int count);
        logic [63:0] data;
        logic [63:0] sel;
        logic [63:0] kind;
        logic        ctrl;
        take_bits(64, data);
        take_bits(1, sel);
        ctrl = 1'b0;
        case (mode)
            0, 1: begin
                ctrl = sel[0] || (mode == 1 && i % 16 == 0);
                if (ctrl) begin
                    take_bits(1, kind);
                    data[7:0] = kind[0] ? bt_os : bt_ctrl;
                end
            end
            2: begin
                serdes_rx_hdr = sel[0] ? 2'b11 : 2'b00;
            end
            3: begin
                ctrl = (i % 2 == 0);
                // flipping bit 0 turns any legal code into an unknown one
                if (is_legal_type(block_type_t'(data[7:0]))) begin
                    data[0] = ~data[0];
                end
            end
            4: begin
                ctrl = (i == 0) || (i == count / 2) || (i == count - 1);
                data[7:0] = (i == count - 1) ? bt_term_0 : bt_start_0;
            end
            default: begin
                ctrl = 1'b0;
            end
        endcase
        if (mode != 2) begin
            serdes_rx_hdr = ctrl ? sync_ctrl : sync_data;
        end
        // the checker only judges control blocks while locked
        if (ctrl && rx_block_lock) begin
            last_type = block_type_t'(data[7:0]);
            ctrl_pending = 1'b1;
        end
        serdes_rx_data = data;
    endtask

    initial begin
        int total_blocks;
        int base;
        rst = 1'b1;
        serdes_rx_hdr = 2'b00;
        serdes_rx_data = '0;
        lfsr_state = 16'd47134;
        last_type = bt_ctrl;
        last_type_bad = 1'b0;
        ctrl_pending = 1'b0;
        ctrl_driven = 1'b0;
        cycle_limit = 0;
        check_total = 0;
        error_total = 0;
        num_tests = 0;
        total_blocks = 0;
        for (int k = 0; k < max_tests * fields; k++) begin
            test_mem[k] = '0;
        end
        $readmemh("tests/phy_rx_tests.txt", test_mem);
        while (num_tests < max_tests && test_mem[num_tests*fields] != 16'd0) begin
            total_blocks += int'(test_mem[num_tests*fields+2]);
            num_tests++;
        end
        if (num_tests == 0) begin
            error_total++;
            $display("no tests could be read from the data file");
        end
        cycle_limit = total_blocks + 20 * (num_tests + 1);

        repeat (16) @(posedge clk);
        for (int t = 0; t < num_tests; t++) begin
            base = t * fields;
            for (int i = 0; i < int'(test_mem[base+2]); i++) begin
                @(negedge clk);
                sample_outputs();
                if (i == 0) begin
                    if (t == 0) begin
                        check_flag(0, "serdes_rx_bitslip", serdes_rx_bitslip, 1'b0);
                        check_flag(0, "serdes_rx_reset_req", serdes_rx_reset_req, 1'b0);
                        check_flag(0, "rx_block_lock", rx_block_lock, 1'b0);
                        check_flag(0, "rx_high_ber", rx_high_ber, 1'b0);
                        check_flag(0, "rx_bad_block", rx_bad_block, 1'b0);
                        check_flag(0, "rx_sequence_error", rx_sequence_error, 1'b0);
                        check_flag(0, "rx_status", rx_status, 1'b0);
                        $display("reset state: %s", (error_total == 0) ? "ok" : "failed");
                        rst = 1'b0;
                    end else begin
                        finish_test(t - 1);
                    end
                    slip_cnt = 0;
                    reset_cnt = 0;
                    bad_cnt = 0;
                    seq_cnt = 0;
                    ctrl_driven = 1'b0;
                end
                drive_block(int'(test_mem[base+1]), i, int'(test_mem[base+2]));
            end
        end
        @(negedge clk);
        sample_outputs();
        if (num_tests > 0) begin
            finish_test(num_tests - 1);
        end

        $display("tests %0d, checks %0d, errors %0d", num_tests, check_total, error_total);
        if (error_total == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
design/phy_rx_pkg.sv
design/rx_block_lock.sv
design/rx_ber_monitor.sv
design/rx_block_checker.sv
design/rx_watchdog.sv
design/phy_rx_monitor_top.sv
tests/phy_rx_monitor_tb.sv

// File: Makefile
# Verilator build and run for the 10G PCS receive link monitor

VERILATOR ?= verilator
TOP       ?= phy_rx_monitor_tb
FILE_LIST ?= build.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_MSG  ?= STATUS: PASS

.PHONY: help build test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(BUILD_DIR)

test: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tests/phy_rx_tests.txt
// code mode blocks | expected lock high_ber status slips resets bad_blocks seq_errors (hex)
// modes: 0 random valid, 1 valid with ctrl every 16, 2 invalid, 3 bad types, 4 start-start, 5 data
0001 0001 0080  0001 0000 0000  0000 0000 0000 0000
0002 0003 0040  0001 0000 0000  0000 0000 0020 0000
0003 0004 0040  0001 0000 0000  0000 0000 0000 0001
0004 0002 0014  0000 0000 0000  0001 0000 0011 0000
0005 0001 002c  0000 0001 0000  0000 0000 0000 0000
0006 0000 0040  0001 0000 0000  0000 0000 0000 0000
0007 0001 0400  0001 0000 0001  0000 0000 0000 0000
0008 0002 0014  0000 0000 0000  0001 0000 0010 0000
0009 0001 006c  0001 0000 0000  0000 0000 0000 0000
000a 0005 0800  0001 0000 0000  0000 0002 0000 0000
